// File: filelist.f
rtl/cpu_pkg.sv
rtl/ctrl_pkg.sv
rtl/step_counter.sv
rtl/micro_sequencer.sv
rtl/alu.sv
rtl/bus_datapath.sv
rtl/flags_reg.sv
rtl/alu_slice_top.sv
testbench/tb_alu_slice.sv

// File: testbench/tb_alu_slice.sv
`timescale 1ns/100ps

module tb_alu_slice import cpu_pkg::*;;

    // edges from driving the strobe to seeing done, the accepting edge included
    localparam int latency_edges = 4;
    localparam int num_random = 24;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    opcode_t                opcode;
    logic [data_width-1:0]  operand;
    logic [data_width-1:0]  acc;
    logic [flags_width-1:0] flags;
    logic [data_width-1:0]  data_out;
    logic                   busy;
    logic                   done;

    // stimulus and expected values, one entry per instruction
    string                  names[$];
    opcode_t                ops[$];
    logic [data_width-1:0]  operands[$];
    logic [data_width-1:0]  exp_acc[$];
    logic [flags_width-1:0] exp_flags[$];
    logic [data_width-1:0]  exp_data[$];

    // reference model state
    logic [data_width-1:0]  m_acc;
    logic [flags_width-1:0] m_flags;
    logic [data_width-1:0]  m_data;

    integer seed;
    int     cycles;
    int     cycle_limit;

    alu_slice_top UUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .operand     (operand),
        .acc         (acc),
        .flags       (flags),
        .data_out    (data_out),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_byte(input string name, input string what,
                              input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("error: %s %s expected 0x%02h actual 0x%02h",
                                name, what, expected, actual));
    endtask

    task automatic check_flags(input string name,
                               input logic [flags_width-1:0] expected,
                               input logic [flags_width-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("error: %s flags (VCZN) expected %04b actual %04b",
                                name, expected, actual));
    endtask

    // instruction rules, C means no borrow for sub
    task automatic model_step(input opcode_t op, input logic [data_width-1:0] value);
        int ua;
        int ub;
        int sa;
        int sb;
        int s;
        ua = int'(m_acc);
        ub = int'(value);
        sa = int'($signed(m_acc));
        sb = int'($signed(value));
        case (op)
            op_lda: m_acc = value;
            op_add: begin
                m_acc = m_acc + value;
                s = sa + sb;
                m_flags[flag_c] = (ua + ub) > 255;
                m_flags[flag_v] = (s > 127) || (s < -128);
            end
            op_sub: begin
                m_acc = m_acc - value;
                s = sa - sb;
                m_flags[flag_c] = ua >= ub;
                m_flags[flag_v] = (s > 127) || (s < -128);
            end
            op_and: m_acc = m_acc & value;
            op_ldf: m_flags = value[flags_width-1:0];
            default: m_data = {{(data_width - flags_width){1'b0}}, m_flags};
        endcase
        if (op inside {op_lda, op_add, op_sub, op_and}) begin
            m_flags[flag_n] = m_acc[data_width-1];
            m_flags[flag_z] = (m_acc == 0);
        end
    endtask

    task automatic add_row(input string name, input opcode_t op,
                           input logic [data_width-1:0] value);
        model_step(op, value);
        names.push_back(name);
        ops.push_back(op);
        operands.push_back(value);
        exp_acc.push_back(m_acc);
        exp_flags.push_back(m_flags);
        exp_data.push_back(m_data);
    endtask

    task automatic build_table();
        int r;
        int pick;
        m_acc = '0;
        m_flags = '0;
        m_data = '0;
        add_row("lda_neg", op_lda, 8'h80);
        add_row("lda_zero", op_lda, 8'h00);
        for (int i = 0; i < data_width; i++)
            add_row($sformatf("lda_bit%0d", i), op_lda, 8'(1 << i));
        add_row("add_setup_7f", op_lda, 8'h7f);
        add_row("add_ovf", op_add, 8'h01);
        add_row("and_keeps_v", op_and, 8'h80);
        add_row("add_setup_ff", op_lda, 8'hff);
        add_row("add_carry_zero", op_add, 8'h01);
        add_row("lda_keeps_c", op_lda, 8'h55);
        add_row("and_keeps_c", op_and, 8'h0f);
        add_row("add_setup_10", op_lda, 8'h10);
        add_row("add_clear_cv", op_add, 8'h20);
        add_row("lda_keeps_clear", op_lda, 8'h00);
        add_row("sub_setup_05", op_lda, 8'h05);
        add_row("sub_no_borrow", op_sub, 8'h03);
        add_row("sub_borrow", op_sub, 8'h05);
        add_row("sub_setup_80", op_lda, 8'h80);
        add_row("sub_ovf", op_sub, 8'h01);
        for (int i = 0; i < flags_width; i++)
            add_row($sformatf("ldf_bit%0d", i), op_ldf, 8'hf0 | 8'(1 << i));
        add_row("ldf_mix", op_ldf, 8'h3b);
        add_row("stf_mix", op_stf, 8'hee);
        add_row("ldf_mix2", op_ldf, 8'hc6);
        add_row("stf_mix2", op_stf, 8'h00);
        // random rows after the directed ones
        for (int i = 0; i < num_random; i++) begin
            r = $random(seed);
            pick = $unsigned(r) % 6;
            r = $random(seed);
            add_row($sformatf("rand_%0d", i), opcode_t'(pick[2:0]), r[7:0]);
        end
    endtask

    // called 2 ns after an edge, returns 2 ns after the edge that shows done
    task automatic run_row(input int idx);
        int edges;
        instr_valid = 1'b1;
        opcode = ops[idx];
        operand = operands[idx];
        @(posedge clk);
        #2;
        edges = 1;
        instr_valid = 1'b0;
        while (!done && edges <= latency_edges) begin
            if (!busy)
                abort_run($sformatf("%s: busy is low before done arrived", names[idx]));
            @(posedge clk);
            #2;
            edges++;
        end
        if (edges != latency_edges)
            abort_run($sformatf("%s: done came after %0d edges instead of %0d",
                                names[idx], edges, latency_edges));
        if (busy)
            abort_run($sformatf("%s: busy still high in the done cycle", names[idx]));
        check_byte(names[idx], "acc", exp_acc[idx], acc);
        check_flags(names[idx], exp_flags[idx], flags);
        check_byte(names[idx], "data_out", exp_data[idx], data_out);
    endtask

    // watchdog against a stuck sequencer
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        opcode = op_lda;
        operand = '0;
        cycles = 0;
        cycle_limit = 0;
        seed = 32'hda7a0f9a;
        build_table();
        cycle_limit = names.size() * 6 + 20;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_byte("reset", "acc", '0, acc);
        check_flags("reset", '0, flags);
        check_byte("reset", "data_out", '0, data_out);
        if (busy || done)
            abort_run("busy or done is high right after reset");
        // each row is strobed in the done cycle of the row before
        for (int i = 0; i < names.size(); i++)
            run_row(i);
        @(posedge clk);
        #2;
        if (done)
            abort_run("done stayed high for more than one cycle");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: rtl/alu_slice_top.sv
`timescale 1ns/100ps

module alu_slice_top import cpu_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  opcode_t                opcode,
    input  logic [data_width-1:0]  operand,
    output logic [data_width-1:0]  acc,
    output logic [flags_width-1:0] flags,
    output logic [data_width-1:0]  data_out,
    output logic                   busy,
    output logic                   done
);

    step_t                  step;
    logic                   last;
    logic                   run;
    bus_src_t               bus_src;
    logic                   load_operand;
    logic                   load_acc;
    logic                   flag_calc;
    logic                   flag_load;
    logic                   flag_show;
    logic                   store_out;
    logic                   alu_sub;
    logic                   alu_and;
    logic [data_width-1:0]  bus;
    logic [data_width-1:0]  operand_reg;
    logic [data_width-1:0]  alu_result;
    logic                   alu_carry;
    logic                   alu_overflow;
    logic                   cv_valid;
    logic [flags_width-1:0] flags_stage;

    micro_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .opcode       (opcode),
        .step         (step),
        .last         (last),
        .run          (run),
        .busy         (busy),
        .done         (done),
        .bus_src      (bus_src),
        .load_operand (load_operand),
        .load_acc     (load_acc),
        .flag_calc    (flag_calc),
        .flag_load    (flag_load),
        .flag_show    (flag_show),
        .store_out    (store_out),
        .alu_sub      (alu_sub),
        .alu_and      (alu_and)
    );

    step_counter u_steps (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .step (step),
        .last (last)
    );

    bus_datapath u_dp (
        .clk          (clk),
        .rst          (rst),
        .bus_src      (bus_src),
        .operand_in   (operand),
        .alu_result   (alu_result),
        .flags_stage  (flags_stage),
        .load_operand (load_operand),
        .load_acc     (load_acc),
        .store_out    (store_out),
        .bus          (bus),
        .operand_reg  (operand_reg),
        .acc          (acc),
        .data_out     (data_out)
    );

    alu u_alu (
        .a        (acc),
        .b        (operand_reg),
        .sub      (alu_sub),
        .band     (alu_and),
        .result   (alu_result),
        .carry    (alu_carry),
        .overflow (alu_overflow),
        .cv_valid (cv_valid)
    );

    flags_reg u_flags (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .carry       (alu_carry),
        .overflow    (alu_overflow),
        .cv_valid    (cv_valid),
        .flag_calc   (flag_calc),
        .flag_load   (flag_load),
        .flag_show   (flag_show),
        .flags_stage (flags_stage),
        .flags       (flags)
    );

endmodule

// File: rtl/flags_reg.sv
`timescale 1ns/100ps

module flags_reg import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [data_width-1:0]  bus,
    input  logic                   carry,
    input  logic                   overflow,
    input  logic                   cv_valid,
    input  logic                   flag_calc,
    input  logic                   flag_load,
    input  logic                   flag_show,
    output logic [flags_width-1:0] flags_stage,
    output logic [flags_width-1:0] flags
);

    // staging flags that stf puts on the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_stage <= '0;
        end else if (flag_load) begin
            flags_stage <= bus[flags_width-1:0];
        end else if (flag_calc) begin
            flags_stage[flag_n] <= bus[data_width-1];
            flags_stage[flag_z] <= (bus == '0);
            // C and V keep their old value when the ALU did not produce them
            if (cv_valid) begin
                flags_stage[flag_c] <= carry;
                flags_stage[flag_v] <= overflow;
            end
        end
    end

    // visible flags trail the staging register by one microstep
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flag_show) begin
            flags <= flags_stage;
        end
    end

endmodule

// File: rtl/bus_datapath.sv
`timescale 1ns/100ps

module bus_datapath import cpu_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_src_t               bus_src,
    input  logic [data_width-1:0]  operand_in,
    input  logic [data_width-1:0]  alu_result,
    input  logic [flags_width-1:0] flags_stage,
    input  logic                   load_operand,
    input  logic                   load_acc,
    input  logic                   store_out,
    output logic [data_width-1:0]  bus,
    output logic [data_width-1:0]  operand_reg,
    output logic [data_width-1:0]  acc,
    output logic [data_width-1:0]  data_out
);

    // internal bus, stands in for the shared tristate bus
    always_comb begin
        case (bus_src)
            src_operand: begin
                // operand port while it is being captured, register afterwards
                bus = load_operand ? operand_in : operand_reg;
            end
            src_alu: begin
                bus = alu_result;
            end
            src_flags: begin
                bus = {{(data_width - flags_width){1'b0}}, flags_stage};
            end
            default: begin
                bus = acc;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_operand) begin
            operand_reg <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (load_acc) begin
            acc <= bus;
        end
    end

    // store register, only stf writes it
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
        end else if (store_out) begin
            data_out <= bus;
        end
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  logic                  sub,
    input  logic                  band,
    output logic [data_width-1:0] result,
    output logic                  carry,
    output logic                  overflow,
    output logic                  cv_valid
);

    logic [data_width-1:0] b_eff;
    logic [data_width:0]   sum;

    // subtract as a + ~b + 1, carry out high means no borrow
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {{data_width{1'b0}}, sub};

    assign carry = sum[data_width];

    // signed overflow when both inputs agree in sign and the result does not
    assign overflow = (a[data_width-1] == b_eff[data_width-1]) &&
                      (sum[data_width-1] != a[data_width-1]);

    always_comb begin
        case ({sub, band})
            2'b00, 2'b10: begin
                result   = sum[data_width-1:0];
                cv_valid = 1'b1;
            end
            2'b01: begin
                result   = a & b;
                cv_valid = 1'b0;
            end
            default: begin
                // pass-through of the operand
                result   = b;
                cv_valid = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/micro_sequencer.sv
`timescale 1ns/100ps

module micro_sequencer import cpu_pkg::*, ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  opcode_t  opcode,
    input  step_t    step,
    input  logic     last,
    output logic     run,
    output logic     busy,
    output logic     done,
    output bus_src_t bus_src,
    output logic     load_operand,
    output logic     load_acc,
    output logic     flag_calc,
    output logic     flag_load,
    output logic     flag_show,
    output logic     store_out,
    output logic     alu_sub,
    output logic     alu_and
);

    logic    executing;
    logic    accept;
    opcode_t op_q;

    assign accept = instr_valid && !executing;
    // run goes high in the accepting cycle so the counter leaves idle at E0
    assign run    = executing || accept;
    assign busy   = executing;

    always_ff @(posedge clk) begin
        if (rst) begin
            executing <= 1'b0;
            done      <= 1'b0;
            op_q      <= op_lda;
        end else begin
            done <= last;
            if (accept) begin
                executing <= 1'b1;
                op_q      <= opcode;
            end else if (last) begin
                executing <= 1'b0;
            end
        end
    end

    // ALU select: 00 add, 10 sub, 01 and, 11 pass operand
    always_comb begin
        case (op_q)
            op_add: {alu_sub, alu_and} = 2'b00;
            op_sub: {alu_sub, alu_and} = 2'b10;
            op_and: {alu_sub, alu_and} = 2'b01;
            default: {alu_sub, alu_and} = 2'b11;
        endcase
    end

    // step decode into one-cycle strobes
    always_comb begin
        bus_src      = src_acc;
        load_operand = 1'b0;
        load_acc     = 1'b0;
        flag_calc    = 1'b0;
        flag_load    = 1'b0;
        flag_show    = 1'b0;
        store_out    = 1'b0;
        case (step)
            st_load: begin
                bus_src      = src_operand;
                load_operand = 1'b1;
            end
            st_exec: begin
                case (op_q)
                    op_lda: begin
                        bus_src   = src_operand;
                        load_acc  = 1'b1;
                        flag_calc = 1'b1;
                    end
                    op_add, op_sub, op_and: begin
                        bus_src   = src_alu;
                        load_acc  = 1'b1;
                        flag_calc = 1'b1;
                    end
                    op_ldf: begin
                        bus_src   = src_operand;
                        flag_load = 1'b1;
                    end
                    op_stf: begin
                        bus_src   = src_flags;
                        store_out = 1'b1;
                    end
                    default: begin
                        bus_src = src_acc;
                    end
                endcase
            end
            st_show: begin
                flag_show = 1'b1;
            end
            default: begin
                bus_src = src_acc;
            end
        endcase
    end

    // strobe is only legal while idle or in the done cycle
    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        instr_valid |-> !busy
    );

    a_calc_load_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(flag_calc && flag_load)
    );

    // fixed latency, done exactly four edges after acceptance
    a_done_latency: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> ##4 done
    );

endmodule

// File: rtl/step_counter.sv
`timescale 1ns/100ps

module step_counter import ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  run,
    output step_t step,
    output logic  last
);

    step_t step_next;

    // last active step wraps back to idle
    assign last = (step == step_t'(num_steps));

    always_comb begin
        step_next = step;
        if (last) begin
            step_next = st_idle;
        end else if (run) begin
            step_next = step_t'(step + 2'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= st_idle;
        end else begin
            step <= step_next;
        end
    end

    // counter must stay parked until the sequencer asks it to run
    a_idle_without_run: assert property (
        @(posedge clk) disable iff (rst)
        (step == st_idle && !run) |=> (step == st_idle)
    );

    // once started, a full pass through the steps follows
    a_steps_in_order: assert property (
        @(posedge clk) disable iff (rst)
        (step == st_load) |=> (step == st_exec) ##1 (step == st_show) ##1 (step == st_idle)
    );

endmodule

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

    // active microsteps per instruction, st_load up to st_show
    localparam int num_steps = 3;

    // microstep encoding, st_show carries the value num_steps
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_load = 2'd1,
        st_exec = 2'd2,
        st_show = 2'd3
    } step_t;

    // source driving the internal bus
    typedef enum logic [1:0] {
        src_operand = 2'd0,
        src_alu     = 2'd1,
        src_acc     = 2'd2,
        src_flags   = 2'd3
    } bus_src_t;

endpackage

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // bus and register width
    localparam int data_width = 8;

    // flags word layout, N in bit 0 up to V in bit 3
    localparam int flags_width = 4;
    localparam int flag_n = 0;
    localparam int flag_z = 1;
    localparam int flag_c = 2;
    localparam int flag_v = 3;

    // instruction set of the execution slice
    typedef enum logic [2:0] {
        // acc <= operand
        op_lda = 3'd0,
        // acc <= acc + operand
        op_add = 3'd1,
        // acc <= acc - operand
        op_sub = 3'd2,
        // acc <= acc & operand
        op_and = 3'd3,
        // flags <= operand[3:0]
        op_ldf = 3'd4,
        // data_out <= {4'h0, flags}
        op_stf = 3'd5
    } opcode_t;

endpackage
